/* hdl/ads5296_pkg.sv */
package ads5296_pkg;

  localparam int NUM_UNITS    = 4;              // adc chips on the board
  localparam int NUM_CHANNELS = 16;             // four lanes per unit
  localparam int NUM_TAPS     = 33;             // 32 data taps + frame tap
  localparam int TAP_HI_BITS  = NUM_TAPS - 32;  // taps living in the HI word
  localparam int WORD_BITS    = 8;              // deserializer output width
  localparam int SNAP_DEPTH   = 16;             // snapshot entries
  localparam int SNAP_LANES   = 4;              // channels 0..3 per entry
  localparam bit IS_MASTER    = 1'b0;           // reported in reg 9 bit 24

  typedef logic [31:0]                   wb_word_t;
  typedef logic [NUM_TAPS-1:0]           tap_mask_t;
  typedef logic [8:0]                    delay_val_t;
  typedef logic [NUM_CHANNELS-1:0]       chan_mask_t;
  typedef logic [WORD_BITS-1:0]          adc_word_t;
  typedef logic [$clog2(SNAP_DEPTH)-1:0] snap_idx_t;
  typedef logic [31:0]                   clk_count_t;
  typedef logic [$clog2(WORD_BITS)-1:0]  slip_t;      // per-lane rotate amount

  localparam adc_word_t FRAME_PATTERN = 8'hF0;  // expected frame clock word

  // word addresses, wb_adr_i[6:2]
  typedef enum logic [4:0] {
    REG_DLOAD_LO  = 5'd0,
    REG_DLOAD_HI  = 5'd1,
    REG_DRST_LO   = 5'd2,
    REG_DRST_HI   = 5'd3,
    REG_DVTC_LO   = 5'd4,
    REG_DVTC_HI   = 5'd5,
    REG_DVAL      = 5'd6,
    REG_FERR      = 5'd7,   // read only
    REG_ISRST     = 5'd8,
    REG_MMCM      = 5'd9,
    REG_LCLK_CNT  = 5'd10,  // 10..14 read only
    REG_FCLK0_CNT = 5'd11,
    REG_FCLK1_CNT = 5'd12,
    REG_FCLK2_CNT = 5'd13,
    REG_FCLK3_CNT = 5'd14,
    REG_BITSLIP   = 5'd15,
    REG_SNAP_TRIG = 5'd16,
    REG_SNAP_IDX  = 5'd17,
    REG_SNAP_DATA = 5'd18   // read only
  } reg_addr_e;

  // everything the register block drives out
  typedef struct packed {
    tap_mask_t  delay_load;
    tap_mask_t  delay_rst;
    tap_mask_t  delay_en_vtc;
    delay_val_t delay_val;
    logic       iserdes_rst;
    logic       mmcm_rst;
    logic       mmcm_clksel;
    chan_mask_t bitslip;
    logic       snapshot_trigger;
    snap_idx_t  snap_idx;
  } adc_ctrl_t;

  // read-only status coming back in
  typedef struct packed {
    clk_count_t                    fclk_err_cnt;
    clk_count_t                    lclk_cnt;
    clk_count_t [NUM_UNITS-1:0]    fclk_cnt;
    wb_word_t                      snap_data;
  } adc_status_t;

endpackage

/* hdl/adc_clock_monitor.sv */
`timescale 1ns/1ps

module adc_clock_monitor (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  logic                                lclk_i,
  input  logic [ads5296_pkg::NUM_UNITS-1:0]   fclk_i,
  input  logic                                frame_stb_i,
  input  ads5296_pkg::adc_word_t              frame_word_i,
  output ads5296_pkg::adc_status_t            count_o
);

  // index 0 is lclk, 1..4 are fclk0..3
  logic [ads5296_pkg::NUM_UNITS:0]       clk_in;
  logic [ads5296_pkg::NUM_UNITS:0]       clk_q;      // previous sample
  logic [ads5296_pkg::NUM_UNITS:0]       clk_rise;
  ads5296_pkg::clk_count_t [ads5296_pkg::NUM_UNITS:0] edge_cnt_q;
  ads5296_pkg::clk_count_t               err_cnt_q;
  logic                                  frame_bad;

  assign clk_in    = {fclk_i, lclk_i};
  assign clk_rise  = clk_in & ~clk_q;
  // only qualified frames count
  assign frame_bad = frame_stb_i && (frame_word_i != ads5296_pkg::FRAME_PATTERN);

  // edge detect and counters, all wrap
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      clk_q      <= '0;
      edge_cnt_q <= '0;
    end else begin
      clk_q <= clk_in;
      for (int i = 0; i <= ads5296_pkg::NUM_UNITS; i++) begin
        if (clk_rise[i]) begin
          edge_cnt_q[i] <= edge_cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // frame error count
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      err_cnt_q <= '0;
    end else if (frame_bad) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  assign count_o.fclk_err_cnt = err_cnt_q;
  assign count_o.lclk_cnt     = edge_cnt_q[0];
  assign count_o.snap_data    = '0;  // filled in by the snapshot buffer

  genvar g;
  for (g = 0; g < ads5296_pkg::NUM_UNITS; g++) begin : g_fclk
    assign count_o.fclk_cnt[g] = edge_cnt_q[g+1];
  end

endmodule

/* hdl/adc_lane_aligner.sv */
`timescale 1ns/1ps

module adc_lane_aligner (
  input  logic                                                    wb_clk_i,
  input  logic                                                    wb_rst_i,
  input  ads5296_pkg::chan_mask_t                                 bitslip_i,
  input  logic                                                    word_stb_i,
  input  ads5296_pkg::adc_word_t [ads5296_pkg::NUM_CHANNELS-1:0]  words_i,
  output logic                                                    aligned_stb_o,
  output ads5296_pkg::adc_word_t [ads5296_pkg::NUM_CHANNELS-1:0]  aligned_o
);

  ads5296_pkg::chan_mask_t                               bitslip_q;  // last bitslip level
  ads5296_pkg::chan_mask_t                               slip_rise;
  ads5296_pkg::slip_t [ads5296_pkg::NUM_CHANNELS-1:0]    slip_q;     // rotate per lane

  // rotate left, upper half of the doubled word after the shift
  function automatic ads5296_pkg::adc_word_t rotl(input ads5296_pkg::adc_word_t w,
                                                  input ads5296_pkg::slip_t n);
    logic [2*ads5296_pkg::WORD_BITS-1:0] dbl;
    dbl = {w, w} << n;
    return dbl[2*ads5296_pkg::WORD_BITS-1 -: ads5296_pkg::WORD_BITS];
  endfunction

  assign slip_rise = bitslip_i & ~bitslip_q;

  // slip amounts, one step per rising bitslip edge, mod 8
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      bitslip_q     <= '0;
      slip_q        <= '0;
      aligned_stb_o <= 1'b0;
    end else begin
      bitslip_q     <= bitslip_i;
      aligned_stb_o <= word_stb_i;  // data follows one cycle later
      for (int ch = 0; ch < ads5296_pkg::NUM_CHANNELS; ch++) begin
        if (slip_rise[ch]) begin
          slip_q[ch] <= slip_q[ch] + 1'b1;  // wraps at 8
        end
      end
    end
  end

  // aligned word register
  always_ff @(posedge wb_clk_i) begin
    if (word_stb_i) begin
      for (int ch = 0; ch < ads5296_pkg::NUM_CHANNELS; ch++) begin
        aligned_o[ch] <= rotl(words_i[ch], slip_q[ch]);
      end
    end
  end

endmodule

/* hdl/adc_snapshot_buffer.sv */
`timescale 1ns/1ps

module adc_snapshot_buffer (
  input  logic                                                   wb_clk_i,
  input  logic                                                   wb_rst_i,
  input  logic                                                   trigger_i,
  input  logic                                                   aligned_stb_i,
  input  ads5296_pkg::adc_word_t [ads5296_pkg::SNAP_LANES-1:0]   aligned_i,
  input  ads5296_pkg::snap_idx_t                                 snap_idx_i,
  output ads5296_pkg::wb_word_t                                  snap_data_o,
  output logic                                                   snap_done_o
);

  typedef enum logic [1:0] {
    SNAP_IDLE,     // waiting for first trigger
    SNAP_CAPTURE,  // filling entries
    SNAP_DONE      // full, readable
  } snap_state_e;

  localparam ads5296_pkg::snap_idx_t LAST_IDX = ads5296_pkg::snap_idx_t'(ads5296_pkg::SNAP_DEPTH - 1);

  snap_state_e              state_q;
  logic                     trig_q;
  logic                     trig_rise;
  logic                     wr_en;
  ads5296_pkg::snap_idx_t   wr_ptr_q;
  ads5296_pkg::wb_word_t    mem [ads5296_pkg::SNAP_DEPTH];

  assign trig_rise = trigger_i & ~trig_q;
  assign wr_en     = (state_q == SNAP_CAPTURE) && aligned_stb_i;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q  <= SNAP_IDLE;
      trig_q   <= 1'b0;
      wr_ptr_q <= '0;
    end else begin
      trig_q <= trigger_i;
      case (state_q)
        SNAP_IDLE, SNAP_DONE: begin
          if (trig_rise) begin  // arm, clears done
            state_q  <= SNAP_CAPTURE;
            wr_ptr_q <= '0;
          end
        end
        SNAP_CAPTURE: begin
          // trigger edges ignored while filling
          if (aligned_stb_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
            if (wr_ptr_q == LAST_IDX) begin
              state_q <= SNAP_DONE;
            end
          end
        end
        default: state_q <= SNAP_IDLE;
      endcase
    end
  end

  // channel 3 in the top byte, channel 0 at the bottom
  always_ff @(posedge wb_clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= ads5296_pkg::wb_word_t'(aligned_i);
    end
  end

  assign snap_data_o = mem[snap_idx_i];  // async readback
  assign snap_done_o = (state_q == SNAP_DONE);

endmodule

/* hdl/wb_ads5296_attach.sv */
`timescale 1ns/1ps

module wb_ads5296_attach (
  input  logic                     wb_clk_i,
  input  logic                     wb_rst_i,
  input  ads5296_pkg::wb_word_t    wb_adr_i,
  input  ads5296_pkg::wb_word_t    wb_dat_i,
  input  logic [3:0]               wb_sel_i,
  input  logic                     wb_we_i,
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  output ads5296_pkg::wb_word_t    wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  input  logic                     mmcm_locked_i,
  input  logic                     snap_done_i,
  input  ads5296_pkg::adc_status_t status_i,
  output ads5296_pkg::adc_ctrl_t   ctrl_o
);

  ads5296_pkg::adc_ctrl_t  ctrl_q;     // all writable fields
  ads5296_pkg::reg_addr_e  reg_addr;   // decoded word address
  ads5296_pkg::wb_word_t   rd_mux;     // current value of addressed reg
  ads5296_pkg::wb_word_t   wr_data;    // bus data merged by byte lane
  ads5296_pkg::wb_word_t   rd_q;       // latched read data
  logic                    ack_q;
  logic                    accept;

  assign reg_addr = ads5296_pkg::reg_addr_e'(wb_adr_i[6:2]);
  // no new cycle on the ack beat, so every access takes two clocks
  assign accept   = wb_stb_i & wb_cyc_i & ~ack_q;

  // read mux, also the base for partial byte writes
  always_comb begin
    case (reg_addr)
      ads5296_pkg::REG_DLOAD_LO:  rd_mux = ctrl_q.delay_load[31:0];
      ads5296_pkg::REG_DLOAD_HI:  rd_mux = 32'(ctrl_q.delay_load[ads5296_pkg::NUM_TAPS-1:32]);
      ads5296_pkg::REG_DRST_LO:   rd_mux = ctrl_q.delay_rst[31:0];
      ads5296_pkg::REG_DRST_HI:   rd_mux = 32'(ctrl_q.delay_rst[ads5296_pkg::NUM_TAPS-1:32]);
      ads5296_pkg::REG_DVTC_LO:   rd_mux = ctrl_q.delay_en_vtc[31:0];
      ads5296_pkg::REG_DVTC_HI:   rd_mux = 32'(ctrl_q.delay_en_vtc[ads5296_pkg::NUM_TAPS-1:32]);
      ads5296_pkg::REG_DVAL:      rd_mux = 32'(ctrl_q.delay_val);
      ads5296_pkg::REG_FERR:      rd_mux = status_i.fclk_err_cnt;
      ads5296_pkg::REG_ISRST:     rd_mux = 32'(ctrl_q.iserdes_rst);
      ads5296_pkg::REG_MMCM: begin
        // one flag per byte
        rd_mux = {7'b0, ads5296_pkg::IS_MASTER, 7'b0, mmcm_locked_i,
                  7'b0, ctrl_q.mmcm_clksel, 7'b0, ctrl_q.mmcm_rst};
      end
      ads5296_pkg::REG_LCLK_CNT:  rd_mux = status_i.lclk_cnt;
      ads5296_pkg::REG_FCLK0_CNT: rd_mux = status_i.fclk_cnt[0];
      ads5296_pkg::REG_FCLK1_CNT: rd_mux = status_i.fclk_cnt[1];
      ads5296_pkg::REG_FCLK2_CNT: rd_mux = status_i.fclk_cnt[2];
      ads5296_pkg::REG_FCLK3_CNT: rd_mux = status_i.fclk_cnt[3];
      ads5296_pkg::REG_BITSLIP:   rd_mux = 32'(ctrl_q.bitslip);
      ads5296_pkg::REG_SNAP_TRIG: rd_mux = {30'b0, snap_done_i, ctrl_q.snapshot_trigger};
      ads5296_pkg::REG_SNAP_IDX:  rd_mux = 32'(ctrl_q.snap_idx);
      ads5296_pkg::REG_SNAP_DATA: rd_mux = status_i.snap_data;  // entry picked by reg 17
      default:                    rd_mux = '0;  // unmapped reads zero
    endcase
  end

  // byte lanes not selected keep their old contents
  always_comb begin
    for (int b = 0; b < 4; b++) begin
      wr_data[8*b +: 8] = wb_sel_i[b] ? wb_dat_i[8*b +: 8] : rd_mux[8*b +: 8];
    end
  end

  // control registers, updated on the accept edge so they land with ack
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ctrl_q <= '0;
    end else if (accept && wb_we_i) begin
      case (reg_addr)
        ads5296_pkg::REG_DLOAD_LO: ctrl_q.delay_load[31:0] <= wr_data;
        ads5296_pkg::REG_DLOAD_HI: begin
          ctrl_q.delay_load[ads5296_pkg::NUM_TAPS-1:32] <=
            wr_data[ads5296_pkg::TAP_HI_BITS-1:0];  // frame tap only
        end
        ads5296_pkg::REG_DRST_LO:  ctrl_q.delay_rst[31:0] <= wr_data;
        ads5296_pkg::REG_DRST_HI: begin
          ctrl_q.delay_rst[ads5296_pkg::NUM_TAPS-1:32] <=
            wr_data[ads5296_pkg::TAP_HI_BITS-1:0];
        end
        ads5296_pkg::REG_DVTC_LO:  ctrl_q.delay_en_vtc[31:0] <= wr_data;
        ads5296_pkg::REG_DVTC_HI: begin
          ctrl_q.delay_en_vtc[ads5296_pkg::NUM_TAPS-1:32] <=
            wr_data[ads5296_pkg::TAP_HI_BITS-1:0];
        end
        ads5296_pkg::REG_DVAL:     ctrl_q.delay_val <= wr_data[8:0];
        ads5296_pkg::REG_ISRST:    ctrl_q.iserdes_rst <= wr_data[0];
        ads5296_pkg::REG_MMCM: begin
          ctrl_q.mmcm_rst    <= wr_data[0];
          ctrl_q.mmcm_clksel <= wr_data[8];
        end
        ads5296_pkg::REG_BITSLIP: begin
          ctrl_q.bitslip <= wr_data[ads5296_pkg::NUM_CHANNELS-1:0];  // one bit per lane
        end
        ads5296_pkg::REG_SNAP_TRIG: ctrl_q.snapshot_trigger <= wr_data[0];  // bit 1 is done, RO
        ads5296_pkg::REG_SNAP_IDX: begin
          ctrl_q.snap_idx <= wr_data[$bits(ads5296_pkg::snap_idx_t)-1:0];
        end
        default: ;  // counters, snap data and holes ignore writes
      endcase
    end
  end

  // ack strobe
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= accept;
    end
  end

  // read data, zero on writes so the bus only shows reads
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      rd_q <= wb_we_i ? '0 : rd_mux;
    end
  end

  assign wb_dat_o = ack_q ? rd_q : '0;  // quiet outside ack
  assign wb_ack_o = ack_q;
  assign wb_err_o = 1'b0;               // never errors
  assign ctrl_o   = ctrl_q;

endmodule

/* hdl/ads5296_attach_top.sv */
`timescale 1ns/1ps

module ads5296_attach_top (
  input  logic                                                   wb_clk_i,
  input  logic                                                   wb_rst_i,
  input  ads5296_pkg::wb_word_t                                  wb_adr_i,
  input  ads5296_pkg::wb_word_t                                  wb_dat_i,
  input  logic [3:0]                                             wb_sel_i,
  input  logic                                                   wb_we_i,
  input  logic                                                   wb_cyc_i,
  input  logic                                                   wb_stb_i,
  output ads5296_pkg::wb_word_t                                  wb_dat_o,
  output logic                                                   wb_ack_o,
  output logic                                                   wb_err_o,
  input  logic                                                   mmcm_locked_i,
  input  logic                                                   lclk_i,
  input  logic [ads5296_pkg::NUM_UNITS-1:0]                      fclk_i,
  input  logic                                                   frame_stb_i,
  input  ads5296_pkg::adc_word_t                                 frame_word_i,
  input  logic                                                   word_stb_i,
  input  ads5296_pkg::adc_word_t [ads5296_pkg::NUM_CHANNELS-1:0] words_i,
  output ads5296_pkg::tap_mask_t                                 delay_load_o,
  output ads5296_pkg::tap_mask_t                                 delay_rst_o,
  output ads5296_pkg::tap_mask_t                                 delay_en_vtc_o,
  output ads5296_pkg::delay_val_t                                delay_val_o,
  output logic                                                   iserdes_rst_o,
  output logic                                                   mmcm_rst_o,
  output logic                                                   mmcm_clksel_o
);

  ads5296_pkg::adc_ctrl_t                                  ctrl;
  ads5296_pkg::adc_status_t                                mon_count;  // snap_data zero here
  ads5296_pkg::adc_status_t                                status;
  ads5296_pkg::wb_word_t                                   snap_data;
  logic                                                    snap_done;
  logic                                                    aligned_stb;
  ads5296_pkg::adc_word_t [ads5296_pkg::NUM_CHANNELS-1:0]  aligned;

  wb_ads5296_attach i_wb_ads5296_attach (
    .wb_clk_i, .wb_rst_i, .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
    .wb_dat_o, .wb_ack_o, .wb_err_o, .mmcm_locked_i,
    .snap_done_i (snap_done),
    .status_i    (status),
    .ctrl_o      (ctrl)
  );

  adc_clock_monitor i_adc_clock_monitor (
    .wb_clk_i, .wb_rst_i, .lclk_i, .fclk_i, .frame_stb_i, .frame_word_i,
    .count_o (mon_count)
  );

  adc_lane_aligner i_adc_lane_aligner (
    .wb_clk_i, .wb_rst_i,
    .bitslip_i     (ctrl.bitslip),
    .word_stb_i,
    .words_i,
    .aligned_stb_o (aligned_stb),
    .aligned_o     (aligned)
  );

  // only the first unit's lanes go into the snapshot
  adc_snapshot_buffer i_adc_snapshot_buffer (
    .wb_clk_i, .wb_rst_i,
    .trigger_i     (ctrl.snapshot_trigger),
    .aligned_stb_i (aligned_stb),
    .aligned_i     (aligned[ads5296_pkg::SNAP_LANES-1:0]),
    .snap_idx_i    (ctrl.snap_idx),
    .snap_data_o   (snap_data),
    .snap_done_o   (snap_done)
  );

  // counters from the monitor, entry data from the buffer
  always_comb begin
    status           = mon_count;
    status.snap_data = snap_data;
  end

  assign delay_load_o   = ctrl.delay_load;
  assign delay_rst_o    = ctrl.delay_rst;
  assign delay_en_vtc_o = ctrl.delay_en_vtc;
  assign delay_val_o    = ctrl.delay_val;
  assign iserdes_rst_o  = ctrl.iserdes_rst;
  assign mmcm_rst_o     = ctrl.mmcm_rst;
  assign mmcm_clksel_o  = ctrl.mmcm_clksel;

endmodule

/* bench/tb_ads5296_tasks.svh */
`ifndef TB_ADS5296_TASKS_SVH
`define TB_ADS5296_TASKS_SVH

// lcg step with 32-bit wrap
function automatic logic [31:0] next_rand();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

// expected lane word where bit i moves up to bit (i + n) mod 8
function automatic ads5296_pkg::adc_word_t ref_rotate(input ads5296_pkg::adc_word_t w,
                                                      input int n);
  ads5296_pkg::adc_word_t r;
  for (int i = 0; i < 8; i++) begin
    r[(i + n) % 8] = w[i];
  end
  return r;
endfunction

task automatic check_value(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
  check_cnt++;
  assert (got === exp) else begin
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    err_cnt++;
  end
endtask

// one bus cycle that starts and ends on a falling edge
task automatic bus_access(input logic we, input logic [4:0] reg_idx,
                          input ads5296_pkg::wb_word_t wdata,
                          output ads5296_pkg::wb_word_t rdata);
  int waited;
  waited   = 0;
  wb_adr_i = {25'b0, reg_idx, 2'b00};  // word address in bits 6:2
  wb_dat_i = wdata;
  wb_we_i  = we;
  wb_cyc_i = 1'b1;
  wb_stb_i = 1'b1;
  @(negedge wb_clk_i);
  while (!wb_ack_o && waited < 8) begin  // ack expected on the first edge already
    @(negedge wb_clk_i);
    waited++;
  end
  if (!wb_ack_o) begin
    $display("access to register %0d got no ack within 8 cycles", reg_idx);
    err_cnt++;
  end
  rdata    = wb_dat_o;  // still inside the ack cycle
  wb_cyc_i = 1'b0;
  wb_stb_i = 1'b0;
  wb_we_i  = 1'b0;
endtask

task automatic write_reg(input logic [4:0] reg_idx, input ads5296_pkg::wb_word_t wdata);
  ads5296_pkg::wb_word_t ack_data;
  bus_access(1'b1, reg_idx, wdata, ack_data);
  check_value("wb_dat_o on write ack", ack_data, 32'h0);  // only reads drive data
endtask

task automatic read_reg(input logic [4:0] reg_idx, output ads5296_pkg::wb_word_t rdata);
  bus_access(1'b0, reg_idx, 32'h0, rdata);
endtask

// every write to reg 15 goes through here so the slip model sees each rising bit
task automatic write_bitslip(input ads5296_pkg::chan_mask_t mask);
  for (int ch = 0; ch < 16; ch++) begin
    if (mask[ch] && !bitslip_model[ch]) begin
      slip_model[ch] = (slip_model[ch] + 1) % 8;
    end
  end
  bitslip_model = mask;
  write_reg(5'd15, 32'(mask));
endtask

`endif

/* bench/tb_ads5296_attach.sv */
`timescale 1ns/1ps

module tb_ads5296_attach;

  localparam int CLK_STEPS  = 64;   // cycles of random lclk/fclk levels
  localparam int NUM_FRAMES = 40;
  localparam int BUS_OPS    = 100;  // upper bound on register accesses
  // run length is 2 cycles per access plus the clock, frame and word strobe phases
  // limit at ten times that
  localparam int TIMEOUT_CYCLES = 10 * (2 * BUS_OPS + CLK_STEPS + 2 * NUM_FRAMES + 56);
  localparam logic [4:0] RT_REGS [10] = '{5'd0, 5'd1, 5'd2, 5'd3, 5'd4,
                                          5'd5, 5'd6, 5'd8, 5'd9, 5'd15};

  logic                                                    wb_clk_i;
  logic                                                    wb_rst_i;
  ads5296_pkg::wb_word_t                                   wb_adr_i;
  ads5296_pkg::wb_word_t                                   wb_dat_i;
  logic [3:0]                                              wb_sel_i;
  logic                                                    wb_we_i;
  logic                                                    wb_cyc_i;
  logic                                                    wb_stb_i;
  ads5296_pkg::wb_word_t                                   wb_dat_o;
  logic                                                    wb_ack_o;
  logic                                                    wb_err_o;
  logic                                                    mmcm_locked_i;
  logic                                                    lclk_i;
  logic [3:0]                                              fclk_i;
  logic                                                    frame_stb_i;
  ads5296_pkg::adc_word_t                                  frame_word_i;
  logic                                                    word_stb_i;
  ads5296_pkg::adc_word_t [ads5296_pkg::NUM_CHANNELS-1:0]  words_i;
  ads5296_pkg::tap_mask_t                                  delay_load_o;
  ads5296_pkg::tap_mask_t                                  delay_rst_o;
  ads5296_pkg::tap_mask_t                                  delay_en_vtc_o;
  ads5296_pkg::delay_val_t                                 delay_val_o;
  logic                                                    iserdes_rst_o;
  logic                                                    mmcm_rst_o;
  logic                                                    mmcm_clksel_o;

  logic [31:0]             lcg_state;
  int                      err_cnt = 0;
  int                      check_cnt = 0;
  int                      test_cnt = 0;
  int                      bus_err_cnt = 0;   // ack / idle data violations
  int                      cycle_cnt;
  logic                    acc_prev;          // access accepted on the last edge
  ads5296_pkg::chan_mask_t bitslip_model = '0;
  int                      slip_model [16] = '{default: 0};

  `include "tb_ads5296_tasks.svh"

  ads5296_attach_top i_ads5296_attach_top (.*);

  always #5 wb_clk_i = ~wb_clk_i;

  // bus protocol watch sampled before the edge updates anything
  always @(posedge wb_clk_i) begin
    if (!wb_rst_i) begin
      assert (wb_ack_o === acc_prev) else begin
        $display("[ERROR] wb_ack_o got %h expected %h", wb_ack_o, acc_prev);
        err_cnt++;
        bus_err_cnt++;
      end
      if (!wb_ack_o) begin
        assert (wb_dat_o === '0) else begin
          $display("[ERROR] wb_dat_o got %h expected %h outside ack", wb_dat_o, 32'h0);
          err_cnt++;
          bus_err_cnt++;
        end
      end
      assert (wb_err_o === 1'b0) else begin
        $display("[ERROR] wb_err_o got %h expected %h", wb_err_o, 1'b0);
        err_cnt++;
        bus_err_cnt++;
      end
    end
    acc_prev <= wb_stb_i & wb_cyc_i & ~wb_ack_o & ~wb_rst_i;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge wb_clk_i);
      cycle_cnt++;
    end
    $display("run stopped by timeout after %0d cycles", cycle_cnt);
    $display("Errors found");
    $finish;
  end

  task automatic report_test(input string name, input int errs0);
    test_cnt++;
    if (err_cnt == errs0) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", test_cnt, name, err_cnt - errs0);
    end
  endtask

  // writable bits per register
  function automatic ads5296_pkg::wb_word_t field_mask(input logic [4:0] r);
    case (r)
      5'd1, 5'd3, 5'd5, 5'd8: return 32'h1;  // frame tap and iserdes reset
      5'd6:                   return 32'h1FF;
      5'd9:                   return 32'h101;
      5'd15:                  return 32'hFFFF;
      default:                return 32'hFFFF_FFFF;
    endcase
  endfunction

  task automatic test_regs();
    int                    errs0;
    ads5296_pkg::wb_word_t raw;
    ads5296_pkg::wb_word_t rd;
    ads5296_pkg::wb_word_t exp;
    ads5296_pkg::wb_word_t val [10];
    errs0 = err_cnt;
    raw = next_rand();
    mmcm_locked_i = raw[20];
    for (int i = 0; i < 10; i++) begin
      raw    = next_rand();
      val[i] = raw & field_mask(RT_REGS[i]);
      if (RT_REGS[i] == 5'd15) begin
        write_bitslip(raw[15:0]);
      end else begin
        write_reg(RT_REGS[i], raw);  // upper junk must be dropped
      end
    end
    for (int i = 0; i < 10; i++) begin
      read_reg(RT_REGS[i], rd);
      exp = val[i];
      if (RT_REGS[i] == 5'd9) begin
        exp = exp | {7'b0, ads5296_pkg::IS_MASTER, 7'b0, mmcm_locked_i, 16'b0};
      end
      check_value($sformatf("wb_dat_o reg %0d", RT_REGS[i]), rd, exp);
    end
    check_value("delay_load_o", delay_load_o, {val[1][0], val[0]});
    check_value("delay_rst_o", delay_rst_o, {val[3][0], val[2]});
    check_value("delay_en_vtc_o", delay_en_vtc_o, {val[5][0], val[4]});
    check_value("delay_val_o", delay_val_o, val[6][8:0]);
    check_value("iserdes_rst_o", iserdes_rst_o, val[7][0]);
    check_value("mmcm_rst_o", mmcm_rst_o, val[8][0]);
    check_value("mmcm_clksel_o", mmcm_clksel_o, val[8][8]);
    report_test("register round trip", errs0);
  endtask

  task automatic test_clocks();
    int                    errs0;
    int                    edges [5];
    logic [4:0]            prev;
    logic [4:0]            cur;
    ads5296_pkg::wb_word_t rd;
    ads5296_pkg::wb_word_t rnd;
    errs0 = err_cnt;
    prev  = '0;  // all low since reset
    for (int c = 0; c < 5; c++) begin
      edges[c] = 0;
    end
    for (int n = 0; n < CLK_STEPS; n++) begin
      rnd = next_rand();
      cur = rnd[22:18];
      for (int c = 0; c < 5; c++) begin
        if (cur[c] && !prev[c]) begin
          edges[c]++;
        end
      end
      {fclk_i, lclk_i} = cur;  // bit 0 is lclk
      prev = cur;
      @(negedge wb_clk_i);
    end
    repeat (2) @(negedge wb_clk_i);  // hold levels until the last edge lands
    for (int c = 0; c < 5; c++) begin
      read_reg(5'(10 + c), rd);
      check_value($sformatf("wb_dat_o reg %0d", 10 + c), rd, 32'(edges[c]));
    end
    report_test("clock counts", errs0);
  endtask

  task automatic test_frames();
    int                    errs0;
    int                    k;
    ads5296_pkg::wb_word_t rnd;
    ads5296_pkg::wb_word_t rd;
    errs0 = err_cnt;
    k     = 0;
    for (int f = 0; f < NUM_FRAMES; f++) begin
      rnd          = next_rand();
      frame_word_i = 8'hF0;
      if (rnd[25:24] == 2'd0) begin  // about one frame in four is bad
        frame_word_i = (rnd[15:8] == 8'hF0) ? 8'h0F : rnd[15:8];
        k++;
      end
      frame_stb_i = 1'b1;
      @(negedge wb_clk_i);
      frame_stb_i  = 1'b0;
      frame_word_i = rnd[7:0];  // word without strobe must not count
      @(negedge wb_clk_i);
    end
    @(negedge wb_clk_i);
    read_reg(5'd7, rd);
    check_value("wb_dat_o reg 7", rd, 32'(k));
    report_test("frame errors", errs0);
  endtask

  task automatic test_snapshot();
    int                      errs0;
    int                      polls;
    int                      pulses [16];
    ads5296_pkg::chan_mask_t mask;
    ads5296_pkg::wb_word_t   rnd;
    ads5296_pkg::wb_word_t   rd;
    ads5296_pkg::wb_word_t   exp_entry [16];
    errs0 = err_cnt;
    for (int ch = 0; ch < 16; ch++) begin
      rnd        = next_rand();
      pulses[ch] = int'(rnd[26:24]);
    end
    for (int p = 0; p < 8; p++) begin
      for (int ch = 0; ch < 16; ch++) begin
        mask[ch] = (pulses[ch] > p);
      end
      if (mask != '0) begin
        write_bitslip(mask);  // pulse the chosen lanes high then low
        write_bitslip('0);
      end
    end
    repeat (2) @(negedge wb_clk_i);
    write_reg(5'd16, 32'h1);  // trigger edge arms capture
    repeat (2) @(negedge wb_clk_i);
    for (int e = 0; e < 16; e++) begin
      for (int ch = 0; ch < 16; ch++) begin
        rnd         = next_rand();
        words_i[ch] = rnd[23:16];
      end
      for (int ch = 0; ch < 4; ch++) begin
        exp_entry[e][8*ch +: 8] = ref_rotate(words_i[ch], slip_model[ch]);  // ch 3 on top
      end
      word_stb_i = 1'b1;
      @(negedge wb_clk_i);
      word_stb_i = 1'b0;
      @(negedge wb_clk_i);
    end
    polls = 0;
    rd    = '0;
    while (!rd[1] && polls < 20) begin
      read_reg(5'd16, rd);
      polls++;
    end
    if (!rd[1]) begin
      $display("snapshot done flag still low after %0d polls", polls);
      err_cnt++;
    end
    for (int e = 0; e < 16; e++) begin
      write_reg(5'd17, 32'(e));
      read_reg(5'd18, rd);
      check_value($sformatf("wb_dat_o reg 18 entry %0d", e), rd, exp_entry[e]);
    end
    write_reg(5'd16, 32'h0);
    report_test("bitslip and snapshot", errs0);
  endtask

  initial begin
    lcg_state     = 32'h7664_1928;
    wb_clk_i      = 1'b0;
    wb_rst_i      = 1'b1;
    wb_adr_i      = '0;
    wb_dat_i      = '0;
    wb_sel_i      = 4'hF;  // full words only
    wb_we_i       = 1'b0;
    wb_cyc_i      = 1'b0;
    wb_stb_i      = 1'b0;
    mmcm_locked_i = 1'b0;
    lclk_i        = 1'b0;
    fclk_i        = '0;
    frame_stb_i   = 1'b0;
    frame_word_i  = '0;
    word_stb_i    = 1'b0;
    words_i       = '0;
    repeat (2) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    @(negedge wb_clk_i);
    test_regs();
    test_clocks();
    test_frames();
    test_snapshot();
    begin : unmapped
      int                    errs0;
      ads5296_pkg::wb_word_t rd;
      errs0 = err_cnt - bus_err_cnt;
      write_reg(5'd25, next_rand());
      read_reg(5'd25, rd);
      check_value("wb_dat_o reg 25", rd, 32'h0);
      report_test("unmapped address and bus timing", errs0);
    end
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* ads5296_attach.f */
+incdir+bench
hdl/ads5296_pkg.sv
hdl/adc_clock_monitor.sv
hdl/adc_lane_aligner.sv
hdl/adc_snapshot_buffer.sv
hdl/wb_ads5296_attach.sv
hdl/ads5296_attach_top.sv
bench/tb_ads5296_attach.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module tb_ads5296_attach \
  -f ads5296_attach.f \
  --Mdir obj_dir

./obj_dir/Vtb_ads5296_attach | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation PASSED"
